/* bench/gl_golden.txt */
# in:  av apc ard aex acause w0v w0i w0x w0c w1v w1i w1x w1c fl fli
# out: idx full empty c0v c0pc c0rd c1v c1pc c1rd exv exc expc (all hex)
1 100 01 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
1 104 02 0 0 1 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
1 108 03 0 0 1 1 0 0 0 0 0 0 0 0 2 0 0 1 100 01 0 0 0 0 0 0
1 10c 04 0 0 1 2 0 0 0 0 0 0 0 0 3 0 0 1 104 02 0 0 0 0 0 0
0 0 0 0 0 1 3 0 0 0 0 0 0 0 0 4 0 0 1 108 03 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 0 0 1 10c 04 0 0 0 0 0 0
1 200 05 0 0 0 0 0 0 0 0 0 0 0 0 4 0 1 0 0 0 0 0 0 0 0 0
1 204 06 0 0 0 0 0 0 0 0 0 0 0 0 5 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 1 4 0 0 1 5 0 0 0 0 6 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 1 200 05 1 204 06 0 0 0
1 300 07 0 0 0 0 0 0 0 0 0 0 0 0 6 0 1 0 0 0 0 0 0 0 0 0
1 304 08 0 0 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 1 7 0 0 0 0 0 0 0 0 8 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 1 6 0 0 0 0 8 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 0 0 1 300 07 1 304 08 0 0 0
1 400 01 0 0 0 0 0 0 0 0 0 0 0 0 8 0 1 0 0 0 0 0 0 0 0 0
1 404 02 0 0 0 0 0 0 0 0 0 0 0 0 9 0 0 0 0 0 0 0 0 0 0 0
1 408 03 0 0 0 0 0 0 0 0 0 0 0 0 a 0 0 0 0 0 0 0 0 0 0 0
1 40c 04 0 0 0 0 0 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0 0 0 0 0
1 410 05 0 0 0 0 0 0 0 0 0 0 0 0 c 0 0 0 0 0 0 0 0 0 0 0
1 414 06 0 0 0 0 0 0 0 0 0 0 0 0 d 0 0 0 0 0 0 0 0 0 0 0
1 418 07 0 0 0 0 0 0 0 0 0 0 0 0 e 0 0 0 0 0 0 0 0 0 0 0
1 41c 08 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 0 0 0 0 0 0 0
1 420 09 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 424 0a 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
1 428 0b 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0
1 42c 0c 0 0 0 0 0 0 0 0 0 0 0 0 3 0 0 0 0 0 0 0 0 0 0 0
1 430 0d 0 0 0 0 0 0 0 0 0 0 0 0 4 0 0 0 0 0 0 0 0 0 0 0
1 434 0e 0 0 0 0 0 0 0 0 0 0 0 0 5 0 0 0 0 0 0 0 0 0 0 0
1 438 0f 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0 0 0 0 0
1 500 1f 0 0 0 0 0 0 0 0 0 0 0 0 7 1 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 1 8 0 0 1 9 0 0 1 9 7 1 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 a 0 0 1 400 01 1 404 02 0 0 0
1 600 01 0 0 0 0 0 0 0 0 0 0 0 0 a 0 1 0 0 0 0 0 0 0 0 0
1 604 02 0 0 0 0 0 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0 0 0 0 0
1 608 03 1 2 0 0 0 0 0 0 0 0 0 0 c 0 0 0 0 0 0 0 0 0 0 0
1 60c 04 0 0 1 c 1 9 1 b 1 5 0 0 d 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 1 a 0 0 0 0 0 0 0 0 e 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 e 0 0 1 600 01 0 0 0 0 0 0
1 700 09 0 0 0 0 0 0 0 0 0 0 0 0 e 0 0 0 0 0 0 0 0 1 5 604
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
1 800 01 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
1 804 02 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
1 808 03 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0
1 80c 04 0 0 1 2 1 6 0 0 0 0 0 0 3 0 0 0 0 0 0 0 0 0 0 0
1 900 0a 0 0 1 0 0 0 0 0 0 0 1 1 4 0 0 0 0 0 0 0 0 0 0 0
1 a00 05 0 0 0 0 0 0 1 1 0 0 0 0 2 0 0 1 800 01 0 0 0 0 0 0
0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 3 0 0 1 804 02 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 0 0 1 a00 05 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 0 1 0 0 0 0 0 0 0 0 0

/* graduation_unit.f */
src/graduation_pkg.sv
src/graduation_list.sv
src/exception_tracker.sv
src/commit_selector.sv
src/graduation_unit.sv
bench/clock_gen.sv
bench/graduation_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := graduation_unit_tb
FILELIST  := graduation_unit.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/graduation_unit_tb.sv */
// ################################################
// Testbench of the graduation unit. Replays the
// golden file cycle by cycle and compares outputs
// ################################################
`timescale 1ns/1ns

module graduation_unit_tb;
    import graduation_pkg::*;

    localparam int MAX_LINES = 256;
    localparam int NCOLS     = 27;   // 15 input columns, 12 expected columns

    logic clk, rstn;
    logic alloc_valid, alloc_ex_valid, wb0_valid, wb0_ex_valid;
    logic wb1_valid, wb1_ex_valid, flush;
    pc_t alloc_pc;
    reg_addr_t alloc_rd;
    exc_cause_t alloc_ex_cause, wb0_ex_cause, wb1_ex_cause;
    gl_index_t wb0_index, wb1_index, flush_index;
    gl_index_t assigned_index;
    logic full, empty, commit0_valid, commit1_valid, exception_valid;
    pc_t commit0_pc, commit1_pc, exception_pc;
    reg_addr_t commit0_rd, commit1_rd;
    exc_cause_t exception_cause;

    logic [31:0] golden [MAX_LINES][NCOLS];
    int num_lines = 0;
    int cur_line = 0;
    int errors = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    clock_gen clk0 (.clk_o(clk), .rstn_o(rstn));

    graduation_unit #(.NUM_ENTRIES(16)) dut0 (
        .clk_i(clk), .rstn_i(rstn),
        .alloc_valid_i(alloc_valid), .alloc_pc_i(alloc_pc), .alloc_rd_i(alloc_rd),
        .alloc_ex_valid_i(alloc_ex_valid), .alloc_ex_cause_i(alloc_ex_cause),
        .wb0_valid_i(wb0_valid), .wb0_index_i(wb0_index),
        .wb0_ex_valid_i(wb0_ex_valid), .wb0_ex_cause_i(wb0_ex_cause),
        .wb1_valid_i(wb1_valid), .wb1_index_i(wb1_index),
        .wb1_ex_valid_i(wb1_ex_valid), .wb1_ex_cause_i(wb1_ex_cause),
        .flush_i(flush), .flush_index_i(flush_index),
        .assigned_index_o(assigned_index), .full_o(full), .empty_o(empty),
        .commit0_valid_o(commit0_valid), .commit0_pc_o(commit0_pc), .commit0_rd_o(commit0_rd),
        .commit1_valid_o(commit1_valid), .commit1_pc_o(commit1_pc), .commit1_rd_o(commit1_rd),
        .exception_valid_o(exception_valid), .exception_cause_o(exception_cause),
        .exception_pc_o(exception_pc)
    );

    task automatic report_mismatch(string name, logic [31:0] act, logic [31:0] exp);
        errors++;
        $display("CHECK FAILED golden line %0d: %s = %h, expected %h", cur_line, name, act, exp);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic check_index(string name, gl_index_t act, gl_index_t exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic check_pc(string name, pc_t act, pc_t exp);
        if (act !== exp) report_mismatch(name, act, exp);
    endtask

    task automatic check_rd(string name, reg_addr_t act, reg_addr_t exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic check_cause(string name, exc_cause_t act, exc_cause_t exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    // Skips comment and blank lines, keeps rows of NCOLS hex values
    task automatic load_golden();
        int fd;
        int n;
        string line;
        logic [31:0] v [NCOLS];
        fd = $fopen("bench/gl_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file bench/gl_golden.txt");
            $display("Errors found");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20], v[21],
                v[22], v[23], v[24], v[25], v[26]);
            if (n != NCOLS) begin
                $display("Golden file row %0d has %0d values instead of %0d", num_lines, n, NCOLS);
                $display("Errors found");
                $fatal(1);
            end
            for (int i = 0; i < NCOLS; i++) golden[num_lines][i] = v[i];
            num_lines++;
        end
        $fclose(fd);
    endtask

    task automatic drive_inputs(int ln);
        alloc_valid    = golden[ln][0][0];
        alloc_pc       = golden[ln][1];
        alloc_rd       = reg_addr_t'(golden[ln][2]);
        alloc_ex_valid = golden[ln][3][0];
        alloc_ex_cause = exc_cause_t'(golden[ln][4]);
        wb0_valid      = golden[ln][5][0];
        wb0_index      = gl_index_t'(golden[ln][6]);
        wb0_ex_valid   = golden[ln][7][0];
        wb0_ex_cause   = exc_cause_t'(golden[ln][8]);
        wb1_valid      = golden[ln][9][0];
        wb1_index      = gl_index_t'(golden[ln][10]);
        wb1_ex_valid   = golden[ln][11][0];
        wb1_ex_cause   = exc_cause_t'(golden[ln][12]);
        flush          = golden[ln][13][0];
        flush_index    = gl_index_t'(golden[ln][14]);
    endtask

    // Payload columns are compared only when their valid is expected high
    task automatic compare_outputs(int ln);
        check_index("assigned_index_o", assigned_index, gl_index_t'(golden[ln][15]));
        check_bit("full_o", full, golden[ln][16][0]);
        check_bit("empty_o", empty, golden[ln][17][0]);
        check_bit("commit0_valid_o", commit0_valid, golden[ln][18][0]);
        if (golden[ln][18][0]) begin
            check_pc("commit0_pc_o", commit0_pc, golden[ln][19]);
            check_rd("commit0_rd_o", commit0_rd, reg_addr_t'(golden[ln][20]));
        end
        check_bit("commit1_valid_o", commit1_valid, golden[ln][21][0]);
        if (golden[ln][21][0]) begin
            check_pc("commit1_pc_o", commit1_pc, golden[ln][22]);
            check_rd("commit1_rd_o", commit1_rd, reg_addr_t'(golden[ln][23]));
        end
        check_bit("exception_valid_o", exception_valid, golden[ln][24][0]);
        if (golden[ln][24][0]) begin
            check_cause("exception_cause_o", exception_cause, exc_cause_t'(golden[ln][25]));
            check_pc("exception_pc_o", exception_pc, golden[ln][26]);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Simulation ran past %0d cycles without finishing", cycle_limit);
            $display("Errors found");
            $fatal(1);
        end
    end

    initial begin
        alloc_valid    = 0;
        alloc_pc       = '0;
        alloc_rd       = '0;
        alloc_ex_valid = 0;
        alloc_ex_cause = '0;
        wb0_valid      = 0;
        wb0_index      = '0;
        wb0_ex_valid   = 0;
        wb0_ex_cause   = '0;
        wb1_valid      = 0;
        wb1_index      = '0;
        wb1_ex_valid   = 0;
        wb1_ex_cause   = '0;
        flush          = 0;
        flush_index    = '0;
        load_golden();
        cycle_limit = num_lines + 10 + 20;
        wait (rstn === 1'b1);
        @(posedge clk);
        #1;
        for (int ln = 0; ln < num_lines; ln++) begin
            cur_line = ln + 1;
            drive_inputs(ln);
            #6;   // Just before the next rising edge
            compare_outputs(ln);
            @(posedge clk);
            #1;
        end
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* bench/clock_gen.sv */
// ################################################
// Testbench clock and reset source.
// 8 ns clock, active-low reset held for 10 cycles
// ################################################
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rstn_o
);
    initial begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rstn_o = 1'b1;   // Released just after an edge
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* src/graduation_unit.sv */
// ################################################
// Graduation stage of the out-of-order core.
// Ties the entry store, the exception tracker and
// the commit selector together
// ################################################
`timescale 1ns/1ns

module graduation_unit #(
    parameter int NUM_ENTRIES = 16   // Power of two from 4 to 32
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    input  logic                       alloc_valid_i,
    input  graduation_pkg::pc_t        alloc_pc_i,
    input  graduation_pkg::reg_addr_t  alloc_rd_i,
    input  logic                       alloc_ex_valid_i,
    input  graduation_pkg::exc_cause_t alloc_ex_cause_i,

    input  logic                       wb0_valid_i,
    input  graduation_pkg::gl_index_t  wb0_index_i,
    input  logic                       wb0_ex_valid_i,
    input  graduation_pkg::exc_cause_t wb0_ex_cause_i,
    input  logic                       wb1_valid_i,
    input  graduation_pkg::gl_index_t  wb1_index_i,
    input  logic                       wb1_ex_valid_i,
    input  graduation_pkg::exc_cause_t wb1_ex_cause_i,

    input  logic                       flush_i,
    input  graduation_pkg::gl_index_t  flush_index_i,

    output graduation_pkg::gl_index_t  assigned_index_o,
    output logic                       full_o,
    output logic                       empty_o,
    output logic                       commit0_valid_o,
    output graduation_pkg::pc_t        commit0_pc_o,
    output graduation_pkg::reg_addr_t  commit0_rd_o,
    output logic                       commit1_valid_o,
    output graduation_pkg::pc_t        commit1_pc_o,
    output graduation_pkg::reg_addr_t  commit1_rd_o,
    output logic                       exception_valid_o,
    output graduation_pkg::exc_cause_t exception_cause_o,
    output graduation_pkg::pc_t        exception_pc_o
);
    import graduation_pkg::*;

    gl_index_t  head;
    gl_count_t  count;
    logic       head_done;
    logic       next_done;
    pc_t        head_pc;
    logic       ex_valid;
    gl_index_t  ex_index;
    logic [1:0] retire_count;
    logic       clear_all;
    logic       alloc_ex;   // Decode exception of an accepted allocation
    logic       wb0_ex;
    logic       wb1_ex;

    assign alloc_ex       = alloc_valid_i && alloc_ex_valid_i && !full_o;
    assign wb0_ex         = wb0_valid_i && wb0_ex_valid_i;
    assign wb1_ex         = wb1_valid_i && wb1_ex_valid_i;
    assign empty_o        = (count == '0);
    assign commit0_pc_o   = head_pc;
    assign exception_pc_o = head_pc;   // Faulting entry sits at the head

    graduation_list #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) list0 (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .alloc_valid_i  (alloc_valid_i),
        .alloc_pc_i     (alloc_pc_i),
        .alloc_rd_i     (alloc_rd_i),
        .alloc_done_i   (alloc_ex_valid_i),
        .wb0_valid_i    (wb0_valid_i),
        .wb1_valid_i    (wb1_valid_i),
        .wb0_index_i    (wb0_index_i),
        .wb1_index_i    (wb1_index_i),
        .flush_i        (flush_i),
        .flush_index_i  (flush_index_i),
        .retire_count_i (retire_count),
        .clear_all_i    (clear_all),
        .head_o         (head),
        .tail_o         (assigned_index_o),
        .count_o        (count),
        .head_done_o    (head_done),
        .next_done_o    (next_done),
        .head_pc_o      (head_pc),
        .next_pc_o      (commit1_pc_o),
        .head_rd_o      (commit0_rd_o),
        .next_rd_o      (commit1_rd_o),
        .full_o         (full_o)
    );

    exception_tracker #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) tracker0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .head_i        (head),
        .alloc_ex_i    (alloc_ex),
        .alloc_index_i (assigned_index_o),
        .alloc_cause_i (alloc_ex_cause_i),
        .wb0_ex_i      (wb0_ex),
        .wb0_index_i   (wb0_index_i),
        .wb0_cause_i   (wb0_ex_cause_i),
        .wb1_ex_i      (wb1_ex),
        .wb1_index_i   (wb1_index_i),
        .wb1_cause_i   (wb1_ex_cause_i),
        .flush_i       (flush_i),
        .flush_index_i (flush_index_i),
        .clear_all_i   (clear_all),
        .ex_valid_o    (ex_valid),
        .ex_index_o    (ex_index),
        .ex_cause_o    (exception_cause_o)
    );

    commit_selector #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) selector0 (
        .head_i         (head),
        .count_i        (count),
        .head_done_i    (head_done),
        .next_done_i    (next_done),
        .ex_valid_i     (ex_valid),
        .ex_index_i     (ex_index),
        .retire_count_o (retire_count),
        .commit0_o      (commit0_valid_o),
        .commit1_o      (commit1_valid_o),
        .raise_ex_o     (exception_valid_o),
        .clear_all_o    (clear_all)
    );

endmodule

/* src/commit_selector.sv */
// ################################################
// Graduation decision for the two head slots.
// Purely combinational from the store and tracker
// registers. Also raises the exception pulse
// ################################################
`timescale 1ns/1ns

module commit_selector #(
    parameter int NUM_ENTRIES = 16
) (
    input  graduation_pkg::gl_index_t head_i,
    input  graduation_pkg::gl_count_t count_i,
    input  logic                      head_done_i,
    input  logic                      next_done_i,
    input  logic                      ex_valid_i,
    input  graduation_pkg::gl_index_t ex_index_i,

    output logic [1:0]                retire_count_o,
    output logic                      commit0_o,
    output logic                      commit1_o,
    output logic                      raise_ex_o,
    output logic                      clear_all_o
);
    import graduation_pkg::*;

    localparam gl_index_t IDX_MASK = gl_index_t'(NUM_ENTRIES - 1);

    gl_index_t next_idx;
    logic      head_valid;
    logic      next_valid;
    logic      head_faults;   // Tracker names the head entry
    logic      next_faults;

    assign next_idx    = (head_i + gl_index_t'(1)) & IDX_MASK;
    assign head_valid  = (count_i != '0);
    assign next_valid  = (count_i >= gl_count_t'(2));
    assign head_faults = ex_valid_i && (ex_index_i == head_i);
    assign next_faults = ex_valid_i && (ex_index_i == next_idx);

    // A done entry not named by the tracker carries no exception
    assign commit0_o  = head_valid && head_done_i && !head_faults;
    assign commit1_o  = commit0_o && next_valid && next_done_i && !next_faults;
    assign raise_ex_o = head_valid && head_done_i && head_faults;

    assign clear_all_o    = raise_ex_o;   // Empties store and tracker next edge
    assign retire_count_o = {1'b0, commit0_o} + {1'b0, commit1_o};

endmodule

/* src/exception_tracker.sv */
// ################################################
// Oldest pending exception of the graduation window.
// Ranks new candidates by age from the head and keeps
// only the oldest one until it graduates or is flushed
// ################################################
`timescale 1ns/1ns

module exception_tracker #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  graduation_pkg::gl_index_t  head_i,

    input  logic                       alloc_ex_i,     // Decode-time exception
    input  graduation_pkg::gl_index_t  alloc_index_i,
    input  graduation_pkg::exc_cause_t alloc_cause_i,
    input  logic                       wb0_ex_i,
    input  graduation_pkg::gl_index_t  wb0_index_i,
    input  graduation_pkg::exc_cause_t wb0_cause_i,
    input  logic                       wb1_ex_i,
    input  graduation_pkg::gl_index_t  wb1_index_i,
    input  graduation_pkg::exc_cause_t wb1_cause_i,

    input  logic                       flush_i,
    input  graduation_pkg::gl_index_t  flush_index_i,
    input  logic                       clear_all_i,

    output logic                       ex_valid_o,
    output graduation_pkg::gl_index_t  ex_index_o,
    output graduation_pkg::exc_cause_t ex_cause_o
);
    import graduation_pkg::*;

    localparam gl_index_t IDX_MASK = gl_index_t'(NUM_ENTRIES - 1);

    logic       ex_valid_q;
    gl_index_t  ex_index_q;
    exc_cause_t ex_cause_q;

    logic       cand_ex    [3];
    gl_index_t  cand_index [3];
    exc_cause_t cand_cause [3];

    logic       best_valid;
    gl_index_t  best_index;
    exc_cause_t best_cause;

    // Distance from the head where zero is the oldest entry
    function automatic gl_index_t age_of(gl_index_t idx, gl_index_t head);
        return (idx - head) & IDX_MASK;
    endfunction

    // Candidate order alloc, wb0, wb1
    assign cand_ex[0]    = alloc_ex_i;
    assign cand_index[0] = alloc_index_i;
    assign cand_cause[0] = alloc_cause_i;
    assign cand_ex[1]    = wb0_ex_i;
    assign cand_index[1] = wb0_index_i;
    assign cand_cause[1] = wb0_cause_i;
    assign cand_ex[2]    = wb1_ex_i;
    assign cand_index[2] = wb1_index_i;
    assign cand_cause[2] = wb1_cause_i;

    always_comb begin
        best_valid = ex_valid_q;
        best_index = ex_index_q;
        best_cause = ex_cause_q;
        for (int i = 0; i < 3; i++) begin
            if (cand_ex[i] && (!best_valid ||
                age_of(cand_index[i], head_i) < age_of(best_index, head_i))) begin
                best_valid = 1'b1;
                best_index = cand_index[i];
                best_cause = cand_cause[i];
            end
        end
        // Entries younger than the flush point are gone
        if (flush_i && best_valid &&
            age_of(best_index, head_i) > age_of(flush_index_i, head_i)) begin
            best_valid = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ex_valid_q <= 1'b0;
        end else if (clear_all_i) begin
            ex_valid_q <= 1'b0;   // Window emptied by the exception
        end else begin
            ex_valid_q <= best_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_index_q <= best_index;
        ex_cause_q <= best_cause;
    end

    assign ex_valid_o = ex_valid_q;
    assign ex_index_o = ex_index_q;
    assign ex_cause_o = ex_cause_q;

    record_in_window: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ex_valid_q |-> (ex_index_q & ~IDX_MASK) == '0);

endmodule

/* src/graduation_list.sv */
// ################################################
// Circular entry store of the graduation window.
// Keeps program order, done bits, pc and rd per entry,
// and moves head, tail and count on alloc, retire,
// flush and clear
// ################################################
`timescale 1ns/1ns

module graduation_list #(
    parameter int NUM_ENTRIES = 16   // Power of two from 4 to 32
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,

    input  logic                      alloc_valid_i,
    input  graduation_pkg::pc_t       alloc_pc_i,
    input  graduation_pkg::reg_addr_t alloc_rd_i,
    input  logic                      alloc_done_i,   // Entry stored already finished

    input  logic                      wb0_valid_i,
    input  logic                      wb1_valid_i,
    input  graduation_pkg::gl_index_t wb0_index_i,
    input  graduation_pkg::gl_index_t wb1_index_i,

    input  logic                      flush_i,
    input  graduation_pkg::gl_index_t flush_index_i,  // Last entry that survives

    input  logic [1:0]                retire_count_i,
    input  logic                      clear_all_i,

    output graduation_pkg::gl_index_t head_o,
    output graduation_pkg::gl_index_t tail_o,
    output graduation_pkg::gl_count_t count_o,
    output logic                      head_done_o,
    output logic                      next_done_o,
    output graduation_pkg::pc_t       head_pc_o,
    output graduation_pkg::pc_t       next_pc_o,
    output graduation_pkg::reg_addr_t head_rd_o,
    output graduation_pkg::reg_addr_t next_rd_o,
    output logic                      full_o
);
    import graduation_pkg::*;

    localparam int        IDX_W     = $clog2(NUM_ENTRIES);
    localparam gl_index_t IDX_MASK  = gl_index_t'(NUM_ENTRIES - 1);
    localparam gl_count_t MAX_COUNT = gl_count_t'(NUM_ENTRIES - 1);

    gl_index_t head_q;
    gl_index_t tail_q;
    gl_count_t count_q;

    gl_index_t next_idx;
    gl_index_t head_nxt;     // Head after this cycle's retirement
    gl_index_t tail_flush;   // Tail after a mispredict flush
    logic      write_enable;

    gl_index_t wb0_age;
    gl_index_t wb1_age;

    pc_t                    pc_q [NUM_ENTRIES];
    reg_addr_t              rd_q [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] done_q;

    // Allocation dropped when full, on flush or on exception clear
    assign write_enable = alloc_valid_i && !full_o && !flush_i && !clear_all_i;

    assign next_idx   = (head_q + gl_index_t'(1)) & IDX_MASK;
    assign head_nxt   = (head_q + gl_index_t'(retire_count_i)) & IDX_MASK;
    assign tail_flush = (flush_index_i + gl_index_t'(1)) & IDX_MASK;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (clear_all_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= head_nxt;
            tail_q  <= tail_flush;
            // Distance is unambiguous since count stays below NUM_ENTRIES
            count_q <= gl_count_t'((tail_flush - head_nxt) & IDX_MASK);
        end else begin
            head_q  <= head_nxt;
            tail_q  <= (tail_q + gl_index_t'(write_enable)) & IDX_MASK;
            count_q <= count_q + gl_count_t'(write_enable) - gl_count_t'(retire_count_i);
        end
    end

    // Done bits set at allocation or by either writeback port
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_q <= '0;
        end else begin
            if (write_enable) begin
                done_q[tail_q[IDX_W-1:0]] <= alloc_done_i;
            end
            if (wb0_valid_i) begin
                done_q[wb0_index_i[IDX_W-1:0]] <= 1'b1;
            end
            if (wb1_valid_i) begin
                done_q[wb1_index_i[IDX_W-1:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_enable) begin
            pc_q[tail_q[IDX_W-1:0]] <= alloc_pc_i;
            rd_q[tail_q[IDX_W-1:0]] <= alloc_rd_i;
        end
    end

    assign head_o      = head_q;
    assign tail_o      = tail_q;     // Index handed to the allocating instruction
    assign count_o     = count_q;
    assign head_done_o = done_q[head_q[IDX_W-1:0]];
    assign next_done_o = done_q[next_idx[IDX_W-1:0]];
    assign head_pc_o   = pc_q[head_q[IDX_W-1:0]];
    assign next_pc_o   = pc_q[next_idx[IDX_W-1:0]];
    assign head_rd_o   = rd_q[head_q[IDX_W-1:0]];
    assign next_rd_o   = rd_q[next_idx[IDX_W-1:0]];
    assign full_o      = (count_q == MAX_COUNT);   // One slot kept free

    assign wb0_age = (wb0_index_i - head_q) & IDX_MASK;
    assign wb1_age = (wb1_index_i - head_q) & IDX_MASK;

    // Writebacks only target entries the dispatch stage has allocated
    wb0_in_window: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb0_valid_i |-> gl_count_t'(wb0_age) < count_q);
    wb1_in_window: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb1_valid_i |-> gl_count_t'(wb1_age) < count_q);

    count_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_q <= MAX_COUNT);

endmodule

/* src/graduation_pkg.sv */
// ################################################
// Shared widths and vector types of the graduation
// window. Every RTL block and the testbench import
// this package for index, count and payload types
// ################################################
package graduation_pkg;

    // Entry index width for windows up to 32 entries
    parameter int GL_INDEX_W = 5;

    // Position of an entry in the window
    typedef logic [GL_INDEX_W-1:0] gl_index_t;

    // Occupied entries from 0 to 32 need one extra bit
    typedef logic [GL_INDEX_W:0] gl_count_t;

    // Instruction address
    typedef logic [31:0] pc_t;

    // Destination register number
    typedef logic [4:0] reg_addr_t;

    // Exception cause code
    typedef logic [3:0] exc_cause_t;

endpackage
